//--- boothRow.sv
// partial-product row instanced once per Booth digit to recode its triplet and place the multiple
`timescale 1ns/1ps

module boothRow #(
    parameter int dataWidth = 32,
    parameter int rowIndex  = 0
) (
    input  logic [2:0]             triplet,
    input  logic [dataWidth+1:0]   multiplicand,
    output logic [2*dataWidth-1:0] partial
);
    import mulPkg::*;

    // room for twice the extended multiplicand plus sign
    localparam int ppWidth  = dataWidth + 3;
    localparam int outWidth = 2 * dataWidth;

    boothDigit_t         digit;
    logic [ppWidth-1:0]  selected;
    logic [ppWidth-1:0]  rowValue;
    logic [outWidth-1:0] extended;

    // radix-4 recoding
    always_comb begin
        digit.neg = triplet[2];
        digit.one = triplet[1] ^ triplet[0];
        digit.two = (triplet == 3'b011) || (triplet == 3'b100);
    end

    always_comb begin
        if (digit.two) begin
            selected = {multiplicand, 1'b0};
        end else if (digit.one) begin
            selected = {multiplicand[dataWidth+1], multiplicand};
        end else begin
            selected = '0;
        end
    end

    // two's complement for negative digits so that -0 wraps to zero
    assign rowValue = digit.neg ? (~selected + ppWidth'(1)) : selected;

    assign extended = {{(outWidth - ppWidth){rowValue[ppWidth-1]}}, rowValue};
    assign partial  = extended << (2 * rowIndex);

endmodule

//--- csaReducer.sv
// carry-save reduction of all Booth rows to one registered sum/carry pair for the final adder
`timescale 1ns/1ps

module csaReducer #(
    parameter int dataWidth = 32
) (
    input  logic                                clk,
    input  logic                                rstN,
    input  logic [dataWidth/2:0][2*dataWidth-1:0] partials,
    input  logic                                valid,
    input  mulPkg::mulMode_t                    mode,
    output logic [2*dataWidth-1:0]              sumWord,
    output logic [2*dataWidth-1:0]              carryWord,
    output logic                                validQ,
    output mulPkg::mulMode_t                    modeQ
);
    import mulPkg::*;

    localparam int rowCount = dataWidth / 2 + 1;
    localparam int outWidth = 2 * dataWidth;

    // rows left after a given number of 3:2 levels
    function automatic int rowsAt(int rows, int level);
        int n;
        n = rows;
        for (int l = 0; l < level; l++) begin
            n = 2 * (n / 3) + n % 3;
        end
        return n;
    endfunction

    function automatic int levelCount(int rows);
        int n;
        int l;
        n = rows;
        l = 0;
        while (n > 2) begin
            n = 2 * (n / 3) + n % 3;
            l++;
        end
        return l;
    endfunction

    localparam int levels = levelCount(rowCount);

    // tree[l] holds the words entering level l
    wire [outWidth-1:0] tree [levels+1][rowCount];

    for (genvar r = 0; r < rowCount; r++) begin : gInput
        assign tree[0][r] = partials[r];
    end

    for (genvar l = 0; l < levels; l++) begin : gLevel
        localparam int nIn    = rowsAt(rowCount, l);
        localparam int groups = nIn / 3;

        for (genvar g = 0; g < groups; g++) begin : gCsa
            wire [outWidth-1:0] x = tree[l][3*g];
            wire [outWidth-1:0] y = tree[l][3*g+1];
            wire [outWidth-1:0] z = tree[l][3*g+2];

            assign tree[l+1][2*g]   = x ^ y ^ z;
            // majority bits move up one weight
            assign tree[l+1][2*g+1] = ((x & y) | (x & z) | (y & z)) << 1;
        end

        // leftover rows skip this level
        for (genvar p = 0; p < nIn % 3; p++) begin : gPass
            assign tree[l+1][2*groups+p] = tree[l][3*groups+p];
        end
    end

    always_ff @(posedge clk) begin
        sumWord   <= tree[levels][0];
        carryWord <= tree[levels][1];
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            validQ <= 1'b0;
            modeQ  <= modeUnsigned;
        end else begin
            validQ <= valid;
            modeQ  <= mode;
        end
    end

endmodule

//--- finalAdder.sv
// last stage: resolves the carry-save pair, flags overflow and presents the product with done
`timescale 1ns/1ps

module finalAdder #(
    parameter int dataWidth = 32
) (
    input  logic                   clk,
    input  logic                   rstN,
    input  logic [2*dataWidth-1:0] sumWord,
    input  logic [2*dataWidth-1:0] carryWord,
    input  logic                   valid,
    input  mulPkg::mulMode_t       mode,
    output logic [2*dataWidth-1:0] product,
    output logic                   overflow,
    output logic                   done
);
    import mulPkg::*;

    logic [2*dataWidth-1:0] fullSum;
    logic [dataWidth-1:0]   upperHalf;
    logic                   overflowNext;

    // carry-propagate add, wraps modulo 2^(2*dataWidth)
    assign fullSum   = sumWord + carryWord;
    assign upperHalf = fullSum[2*dataWidth-1:dataWidth];

    // signed needs the upper half to copy the low-half sign bit
    always_comb begin
        if (mode == modeSigned) begin
            overflowNext = upperHalf != {dataWidth{fullSum[dataWidth-1]}};
        end else begin
            overflowNext = |upperHalf;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            product  <= '0;
            overflow <= 1'b0;
            done     <= 1'b0;
        end else begin
            done <= valid;
            if (valid) begin
                product  <= fullSum;
                overflow <= overflowNext;
            end
        end
    end

    assert property (@(posedge clk) disable iff (!rstN) done |-> !$isunknown({product, overflow}))
        else $error("result reported with unknown bits");

endmodule

//--- mulIssue.sv
// issue stage: captures operands on start and hands extended multiplicand and Booth triplets to the rows
`timescale 1ns/1ps

module mulIssue #(
    parameter int dataWidth = 32
) (
    input  logic                     clk,
    input  logic                     rstN,
    input  logic                     start,
    input  logic [dataWidth-1:0]     a,
    input  logic [dataWidth-1:0]     b,
    input  mulPkg::mulMode_t         mode,
    output logic [dataWidth+1:0]     multiplicand,
    output logic [dataWidth/2:0][2:0] triplets,
    output mulPkg::mulMode_t         modeQ,
    output logic                     valid
);
    import mulPkg::*;

    localparam int rowCount = dataWidth / 2 + 1;

    logic [dataWidth-1:0] aQ;
    logic [dataWidth-1:0] bQ;
    logic                 aFill;
    logic                 bFill;
    logic [dataWidth+2:0] multiplierExt;

    // operand payload, held until the next start
    always_ff @(posedge clk) begin
        if (start) begin
            aQ <= a;
            bQ <= b;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            valid <= 1'b0;
            modeQ <= modeUnsigned;
        end else begin
            valid <= start;
            if (start) begin
                modeQ <= mode;
            end
        end
    end

    // sign extension only in signed mode
    assign aFill = (modeQ == modeSigned) & aQ[dataWidth-1];
    assign bFill = (modeQ == modeSigned) & bQ[dataWidth-1];

    assign multiplicand  = {{2{aFill}}, aQ};
    assign multiplierExt = {{2{bFill}}, bQ, 1'b0};

    // overlapping triplets, row i sees original bits 2i+1..2i-1
    for (genvar i = 0; i < rowCount; i++) begin : gTriplet
        assign triplets[i] = multiplierExt[2*i+2 -: 3];
    end

    assert property (@(posedge clk) disable iff (!rstN) start |-> !$isunknown({a, b, mode}))
        else $error("start sampled with unknown operands or mode");

endmodule

//--- mulPkg.sv
// shared types and default width for the Booth multiply unit that every RTL file imports

package mulPkg;

    // operand width used when the top level is not overridden
    localparam int defaultWidth = 32;

    // signedness of both operands
    typedef enum logic {
        modeUnsigned = 1'b0,
        modeSigned   = 1'b1
    } mulMode_t;

    // one radix-4 Booth digit that is zero when neither one nor two is set
    typedef struct packed {
        logic neg;
        logic one;
        logic two;
    } boothDigit_t;

endpackage

//--- mulUnit.sv
// top of the pipelined Booth multiplier: issue, rows, carry-save tree and final add
`timescale 1ns/1ps

module mulUnit #(
    parameter int dataWidth = mulPkg::defaultWidth
) (
    input  logic                   clk,
    input  logic                   rstN,
    input  logic                   start,
    input  logic [dataWidth-1:0]   a,
    input  logic [dataWidth-1:0]   b,
    input  mulPkg::mulMode_t       mode,
    output logic                   done,
    output logic [2*dataWidth-1:0] product,
    output logic                   overflow
);
    import mulPkg::*;

    localparam int rowCount = dataWidth / 2 + 1;

    logic [dataWidth+1:0]                  multiplicand;
    logic [dataWidth/2:0][2:0]             triplets;
    logic [dataWidth/2:0][2*dataWidth-1:0] partials;
    mulMode_t                              issueMode;
    logic                                  issueValid;
    logic [2*dataWidth-1:0]                sumWord;
    logic [2*dataWidth-1:0]                carryWord;
    mulMode_t                              csaMode;
    logic                                  csaValid;

    mulIssue #(.dataWidth(dataWidth)) u_issue (
        .clk          (clk),
        .rstN         (rstN),
        .start        (start),
        .a            (a),
        .b            (b),
        .mode         (mode),
        .multiplicand (multiplicand),
        .triplets     (triplets),
        .modeQ        (issueMode),
        .valid        (issueValid)
    );

    // one row per Booth digit
    for (genvar i = 0; i < rowCount; i++) begin : gRow
        boothRow #(.dataWidth(dataWidth), .rowIndex(i)) u_row (
            .triplet      (triplets[i]),
            .multiplicand (multiplicand),
            .partial      (partials[i])
        );
    end

    csaReducer #(.dataWidth(dataWidth)) u_reducer (
        .clk       (clk),
        .rstN      (rstN),
        .partials  (partials),
        .valid     (issueValid),
        .mode      (issueMode),
        .sumWord   (sumWord),
        .carryWord (carryWord),
        .validQ    (csaValid),
        .modeQ     (csaMode)
    );

    finalAdder #(.dataWidth(dataWidth)) u_adder (
        .clk       (clk),
        .rstN      (rstN),
        .sumWord   (sumWord),
        .carryWord (carryWord),
        .valid     (csaValid),
        .mode      (csaMode),
        .product   (product),
        .overflow  (overflow),
        .done      (done)
    );

endmodule

//--- sim.f
mulPkg.sv
mulIssue.sv
boothRow.sv
csaReducer.sv
finalAdder.sv
mulUnit.sv
tbMulUnit.sv

//--- tbMulUnit.sv
// self-checking testbench for mulUnit, random and corner operands checked against a queue model
`timescale 1ns/1ps

module tbMulUnit;
    import mulPkg::*;

    localparam int w = defaultWidth;

    typedef struct packed {
        logic [2*w-1:0] product;
        logic           overflow;
        logic [31:0]    doneCycle;
    } expect_t;

    logic           clk;
    logic           rstN;
    logic           start;
    logic [w-1:0]   a;
    logic [w-1:0]   b;
    mulMode_t       mode;
    logic           done;
    logic [2*w-1:0] product;
    logic           overflow;

    expect_t     expectQ[$];
    expect_t     seenRec;
    logic [31:0] cycleCount = 0;
    string       testName = "reset";
    int          checkCount = 0;
    int          errorCount = 0;
    int          testCount = 0;
    int          checksAtStart = 0;
    int          errorsAtStart = 0;

    mulUnit #(.dataWidth(w)) u_dut (
        .clk      (clk),
        .rstN     (rstN),
        .start    (start),
        .a        (a),
        .b        (b),
        .mode     (mode),
        .done     (done),
        .product  (product),
        .overflow (overflow)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) cycleCount <= cycleCount + 1;

    task automatic compareValue(string name, logic [2*w-1:0] expected, logic [2*w-1:0] actual);
        checkCount++;
        if (expected !== actual) begin
            errorCount++;
            $display("error %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    // reference result from native 64-bit arithmetic and the fit-in-one-width rule
    function automatic expect_t modelProduct(logic [w-1:0] x, logic [w-1:0] y, mulMode_t m);
        expect_t     r;
        longint      sx;
        longint      sy;
        longint      sp;
        logic [63:0] up;
        r = '0;
        if (m == modeSigned) begin
            sx = $signed(x);
            sy = $signed(y);
            sp = sx * sy;
            r.product  = sp;
            r.overflow = (sp > 64'sd2147483647) || (sp < -64'sd2147483648);
        end else begin
            up = {32'b0, x} * {32'b0, y};
            r.product  = up;
            r.overflow = up > 64'h0000_0000_ffff_ffff;
        end
        return r;
    endfunction

    // called at 1 ns after a rising edge, returns at the same point one cycle on
    task automatic issueOp(logic [w-1:0] x, logic [w-1:0] y, mulMode_t m);
        expect_t rec;
        rec = modelProduct(x, y, m);
        // start sampled on the next edge, result visible two edges later
        rec.doneCycle = cycleCount + 3;
        expectQ.push_back(rec);
        start = 1'b1;
        a = x;
        b = y;
        mode = m;
        @(posedge clk);
        #1;
    endtask

    task automatic idleCycles(int n);
        start = 1'b0;
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic beginTest(string name);
        testName = name;
        checksAtStart = checkCount;
        errorsAtStart = errorCount;
    endtask

    task automatic finishTest(int limit);
        int cyc;
        start = 1'b0;
        cyc = 0;
        while (expectQ.size() > 0 && cyc < limit) begin
            @(posedge clk);
            #1;
            cyc++;
        end
        if (expectQ.size() > 0) begin
            $display("timeout: %0d results never arrived in %s", expectQ.size(), testName);
            errorCount++;
            expectQ.delete();
        end
        testCount++;
        $display("test %s: %0d checks, %0d errors", testName,
                 checkCount - checksAtStart, errorCount - errorsAtStart);
    endtask

    // results are sampled mid-cycle, away from the edges
    always @(negedge clk) begin
        if (rstN && done) begin
            if (expectQ.size() == 0) begin
                errorCount++;
                $display("done pulsed with no operation outstanding in %s", testName);
            end else begin
                seenRec = expectQ.pop_front();
                compareValue({testName, " product"}, seenRec.product, product);
                compareValue({testName, " overflow"}, seenRec.overflow, overflow);
                compareValue({testName, " latency"}, seenRec.doneCycle, cycleCount);
            end
        end
    end

    initial begin
        logic [w-1:0] corners [7];
        rstN = 1'b0;
        start = 1'b0;
        a = '0;
        b = '0;
        mode = modeUnsigned;
        void'($urandom(32'h1b7b_050f));
        corners = '{32'h0, 32'h1, 32'hffff_ffff, 32'h8000_0000,
                    32'h7fff_ffff, 32'haaaa_aaaa, 32'h5555_5555};
        repeat (8) @(posedge clk);
        #1;
        rstN = 1'b1;

        beginTest("resetIdle");
        repeat (6) begin
            @(negedge clk);
            compareValue("resetIdle done", 0, done);
            compareValue("resetIdle product", 0, product);
            compareValue("resetIdle overflow", 0, overflow);
            @(posedge clk);
            #1;
        end
        finishTest(20);

        beginTest("unsignedRandom");
        repeat (200) begin
            issueOp($urandom(), $urandom(), modeUnsigned);
            idleCycles($urandom_range(0, 2));
        end
        finishTest(20);

        beginTest("signedRandom");
        repeat (200) begin
            issueOp($urandom(), $urandom(), modeSigned);
            idleCycles($urandom_range(0, 2));
        end
        finishTest(20);

        beginTest("corners");
        foreach (corners[i]) begin
            foreach (corners[j]) begin
                issueOp(corners[i], corners[j], modeUnsigned);
                issueOp(corners[i], corners[j], modeSigned);
            end
        end
        finishTest(20);

        // products right at and just past the one-width limits
        beginTest("overflowBoundary");
        issueOp(32'd65535, 32'd65537, modeUnsigned);
        issueOp(32'd65536, 32'd65536, modeUnsigned);
        issueOp(32'hffff_ffff, 32'd1, modeUnsigned);
        issueOp(32'h0000_8000, 32'hffff_0000, modeSigned);
        issueOp(32'h0000_8000, 32'h0001_0000, modeSigned);
        issueOp(32'h7fff_ffff, 32'd1, modeSigned);
        issueOp(32'h8000_0000, 32'hffff_ffff, modeSigned);
        issueOp(32'd46340, 32'd46340, modeSigned);
        issueOp(32'd46341, 32'd46341, modeSigned);
        issueOp(32'hffff_ffff, 32'hffff_ffff, modeSigned);
        finishTest(20);

        beginTest("burst");
        repeat (64) begin
            issueOp($urandom(), $urandom(), mulMode_t'($urandom_range(0, 1)));
        end
        finishTest(20);

        $display("%0d tests, %0d checks, %0d errors", testCount, checkCount, errorCount);
        if (errorCount == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule
